/* decodeStage.f */
rtl/decodePkg.sv
rtl/instrDecoder.sv
rtl/regFileBypass.sv
rtl/hazardDetect.sv
rtl/decodeStage.sv
verification/decodeStageTb.sv

/* rtl/decodePkg.sv */
// Word, index, opcode and control types, ALU codes, opcode constants, NOP instruction
`default_nettype none

package decodePkg;

  typedef logic [15:0] wordT;   // Data word
  typedef logic [15:0] instrT;  // Instruction word
  typedef logic [2:0]  regIdxT; // Register index
  typedef logic [4:0]  opcodeT; // Instruction bits 15:11
  typedef logic [3:0]  aluOpT;  // ALU operation for execute

  // Which instruction field names the destination register
  typedef enum logic [1:0] {
    dstRs = 2'd0, // Bits 10:8
    dstRt = 2'd1, // Bits 7:5
    dstRd = 2'd2, // Bits 4:2
    dstR7 = 2'd3  // Link register
  } regDstT;

  // ALU operations; aluArith and aluShift defer to the funct bits
  localparam aluOpT aluAdd   = 4'h0;
  localparam aluOpT aluXor   = 4'h1;
  localparam aluOpT aluAndn  = 4'h2;
  localparam aluOpT aluRol   = 4'h3;
  localparam aluOpT aluSll   = 4'h4;
  localparam aluOpT aluRor   = 4'h5;
  localparam aluOpT aluSrl   = 4'h6;
  localparam aluOpT aluArith = 4'h7;
  localparam aluOpT aluShift = 4'h8;
  localparam aluOpT aluPassA = 4'h9; // Branch compare on Rs
  localparam aluOpT aluPassB = 4'ha; // Load immediate
  localparam aluOpT aluSlbi  = 4'hb; // Rs shifted up by 8 OR imm8
  localparam aluOpT aluBtr   = 4'hc; // Bit reverse

  localparam opcodeT opHalt  = 5'b00000;
  localparam opcodeT opNop   = 5'b00001;
  localparam opcodeT opJ     = 5'b00100;
  localparam opcodeT opJr    = 5'b00101;
  localparam opcodeT opJal   = 5'b00110;
  localparam opcodeT opJalr  = 5'b00111;
  localparam opcodeT opAddi  = 5'b01000;
  localparam opcodeT opSubi  = 5'b01001;
  localparam opcodeT opXori  = 5'b01010;
  localparam opcodeT opAndni = 5'b01011;
  localparam opcodeT opBeqz  = 5'b01100;
  localparam opcodeT opBnez  = 5'b01101;
  localparam opcodeT opBltz  = 5'b01110;
  localparam opcodeT opBgez  = 5'b01111;
  localparam opcodeT opSt    = 5'b10000;
  localparam opcodeT opLd    = 5'b10001;
  localparam opcodeT opSlbi  = 5'b10010;
  localparam opcodeT opStu   = 5'b10011;
  localparam opcodeT opRoli  = 5'b10100;
  localparam opcodeT opSlli  = 5'b10101;
  localparam opcodeT opRori  = 5'b10110;
  localparam opcodeT opSrli  = 5'b10111;
  localparam opcodeT opLbi   = 5'b11000;
  localparam opcodeT opBtr   = 5'b11001;
  localparam opcodeT opShift = 5'b11010;
  localparam opcodeT opAlu   = 5'b11011;
  localparam opcodeT opSeq   = 5'b11100;
  localparam opcodeT opSlt   = 5'b11101;
  localparam opcodeT opSle   = 5'b11110;
  localparam opcodeT opSco   = 5'b11111;

  localparam instrT nopInstr = 16'h0800; // Opcode opNop, all fields zero

endpackage

`default_nettype wire

/* rtl/decodeStage.sv */
// Decode stage top with replay register, instruction select, immediates and destination mux
`default_nettype none

module decodeStage #(
  parameter int numRegs = 8
) (
  input  wire                     clk,
  input  wire                     arstN,
  input  wire  decodePkg::instrT  instructionIn,
  input  wire                     regWrtIn,
  input  wire  decodePkg::regIdxT writeRegSelIn,
  input  wire  decodePkg::wordT   writeData,
  input  wire                     dataMemStall,
  input  wire                     instrMemStall,
  input  wire                     pcSrcX,
  input  wire                     memRd,
  input  wire  decodePkg::regIdxT registerRtIdEx,
  output decodePkg::wordT         readData1,
  output decodePkg::wordT         readData2,
  output decodePkg::wordT         imm5Ext,
  output decodePkg::wordT         imm8Ext,
  output decodePkg::wordT         imm11Ext,
  output logic                    immSrc,
  output logic [1:0]              bSrc,
  output logic [1:0]              regSrc,
  output logic [1:0]              functOut,   // Instruction bits 1:0
  output logic [1:0]              brchCndSel, // Instruction bits 12:11
  output decodePkg::aluOpT        aluOp,
  output logic                    invA,
  output logic                    invB,
  output logic                    memWrt,
  output logic                    regWrtOut,
  output decodePkg::regIdxT       registerRs,
  output decodePkg::regIdxT       registerRt,
  output decodePkg::regIdxT       writeRegSelOut,
  output logic                    branch,
  output logic                    set,
  output logic                    sub,
  output logic                    memEn,
  output logic                    aluJmp,
  output logic                    slbi,
  output logic                    halt,
  output logic                    btr,
  output logic                    jmp,
  output logic                    hazard,
  output logic                    flush,
  output decodePkg::instrT        instructionOut
);

  decodePkg::instrT  selInstr;
  decodePkg::instrT  prevInstr; // Instruction held back by a hazard
  logic              prevHaz;
  decodePkg::regDstT regDst;
  logic              zeroExt;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevInstr <= decodePkg::nopInstr;
      prevHaz   <= 1'b0;
    end else begin
      prevInstr <= instructionIn;
      prevHaz   <= hazard;
    end
  end

  always_comb begin
    if (hazard || flush || dataMemStall) begin
      selInstr = decodePkg::nopInstr; // Bubble
    end else if (prevHaz && (prevInstr != decodePkg::nopInstr)) begin
      selInstr = prevInstr; // Replay after the load-use bubble
    end else begin
      selInstr = instructionIn;
    end
  end

  assign instructionOut = selInstr;
  assign registerRs     = selInstr[10:8];
  assign registerRt     = selInstr[7:5];
  assign functOut       = selInstr[1:0];
  assign brchCndSel     = selInstr[12:11];

  instrDecoder decoder_i (
    .opcode  (selInstr[15:11]),
    .aluOp   (aluOp),
    .regSrc  (regSrc),
    .bSrc    (bSrc),
    .regDst  (regDst),
    .regWrt  (regWrtOut),
    .slbi    (slbi),
    .branch  (branch),
    .zeroExt (zeroExt),
    .set     (set),
    .sub     (sub),
    .memEn   (memEn),
    .invA    (invA),
    .invB    (invB),
    .memWrt  (memWrt),
    .immSrc  (immSrc),
    .aluJmp  (aluJmp),
    .halt    (halt),
    .btr     (btr),
    .jmp     (jmp)
  );

  assign imm5Ext  = zeroExt ? {11'd0, selInstr[4:0]} : {{11{selInstr[4]}}, selInstr[4:0]};
  assign imm8Ext  = zeroExt ? {8'd0, selInstr[7:0]} : {{8{selInstr[7]}}, selInstr[7:0]};
  assign imm11Ext = {{5{selInstr[10]}}, selInstr[10:0]}; // Always signed

  always_comb begin
    case (regDst)
      decodePkg::dstRs: writeRegSelOut = selInstr[10:8];
      decodePkg::dstRt: writeRegSelOut = selInstr[7:5];
      decodePkg::dstRd: writeRegSelOut = selInstr[4:2];
      default:          writeRegSelOut = 3'd7; // Link register
    endcase
  end

  regFileBypass #(
    .numRegs (numRegs)
  ) regFile_i (
    .clk         (clk),
    .arstN       (arstN),
    .read1RegSel (registerRs),
    .read2RegSel (registerRt),
    .writeRegSel (writeRegSelIn),
    .writeData   (writeData),
    .writeEn     (regWrtIn),
    .read1Data   (readData1),
    .read2Data   (readData2)
  );

  // Hazard looks at the raw fetched instruction, not the replayed one
  hazardDetect hazard_i (
    .clk       (clk),
    .arstN     (arstN),
    .stall     (dataMemStall || instrMemStall),
    .memRd     (memRd),
    .pcSrcX    (pcSrcX),
    .rtIdEx    (registerRtIdEx),
    .readRegA  (instructionIn[10:8]),
    .readRegB  (instructionIn[7:5]),
    .hazardOut (hazard),
    .flushOut  (flush)
  );

  // Squashed slots must not write a register or touch memory
  flushNoSideEffects: assert property (@(posedge clk) disable iff (!arstN)
    flush |-> (!regWrtOut && !memWrt && !memEn))
    else $error("flushed slot still writes a register or memory");

endmodule

`default_nettype wire

/* rtl/hazardDetect.sv */
// Load-use hazard detection and the branch flush state machine
`default_nettype none

module hazardDetect (
  input  wire                     clk,
  input  wire                     arstN,
  input  wire                     stall,
  input  wire                     memRd,
  input  wire                     pcSrcX,
  input  wire  decodePkg::regIdxT rtIdEx,
  input  wire  decodePkg::regIdxT readRegA,
  input  wire  decodePkg::regIdxT readRegB,
  output logic                    hazardOut,
  output logic                    flushOut
);

  typedef enum logic {
    flushIdle = 1'b0,
    flushHold = 1'b1  // Second flush cycle pending
  } flushStateT;

  flushStateT state;
  flushStateT nextState;

  // Load in execute writes a register this instruction reads
  assign hazardOut = memRd && ((rtIdEx == readRegA) || (rtIdEx == readRegB));

  always_comb begin
    nextState = state;
    case (state)
      flushIdle: begin
        if (pcSrcX) begin
          nextState = flushHold;
        end
      end
      flushHold: begin
        if (pcSrcX) begin
          nextState = flushHold; // Back-to-back taken branch
        end else if (!stall) begin
          nextState = flushIdle;
        end
      end
      default: nextState = flushIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= flushIdle;
    end else begin
      state <= nextState;
    end
  end

  assign flushOut = pcSrcX || (state == flushHold);

  // Flush state needs clean branch and stall inputs
  flushInputsKnown: assert property (@(posedge clk) disable iff (!arstN)
    !$isunknown({pcSrcX, stall}))
    else $error("branch taken or stall input unknown");

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
// Opcode to control signal decode table with destination-select code
`default_nettype none

module instrDecoder (
  input  wire  decodePkg::opcodeT opcode,
  output decodePkg::aluOpT        aluOp,
  output logic [1:0]              regSrc,
  output logic [1:0]              bSrc,
  output decodePkg::regDstT       regDst,
  output logic                    regWrt,
  output logic                    slbi,
  output logic                    branch,
  output logic                    zeroExt,
  output logic                    set,
  output logic                    sub,
  output logic                    memEn,
  output logic                    invA,
  output logic                    invB,
  output logic                    memWrt,
  output logic                    immSrc,
  output logic                    aluJmp,
  output logic                    halt,
  output logic                    btr,
  output logic                    jmp
);

  // Write-back source
  localparam logic [1:0] regSrcAlu  = 2'd0;
  localparam logic [1:0] regSrcMem  = 2'd1;
  localparam logic [1:0] regSrcPc   = 2'd2; // PC + 2 for links
  localparam logic [1:0] regSrcCond = 2'd3;

  // ALU B operand source
  localparam logic [1:0] bSrcReg  = 2'd0;
  localparam logic [1:0] bSrcImm5 = 2'd1;
  localparam logic [1:0] bSrcImm8 = 2'd2;

  always_comb begin
    aluOp   = decodePkg::aluAdd; // Unknown opcodes fall out as NOP
    regSrc  = regSrcAlu;
    bSrc    = bSrcReg;
    regDst  = decodePkg::dstRs;
    regWrt  = 1'b0;
    slbi    = 1'b0;
    branch  = 1'b0;
    zeroExt = 1'b0;
    set     = 1'b0;
    sub     = 1'b0;
    memEn   = 1'b0;
    invA    = 1'b0;
    invB    = 1'b0;
    memWrt  = 1'b0;
    immSrc  = 1'b0;
    aluJmp  = 1'b0;
    halt    = 1'b0;
    btr     = 1'b0;
    jmp     = 1'b0;
    case (opcode)
      decodePkg::opHalt: halt = 1'b1;
      decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
      decodePkg::opRoli, decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli: begin
        regWrt = 1'b1;
        bSrc   = bSrcImm5;
        regDst = decodePkg::dstRt;
        case (opcode)
          decodePkg::opSubi: begin
            sub  = 1'b1;
            invA = 1'b1; // imm - Rs
          end
          decodePkg::opXori: begin
            aluOp   = decodePkg::aluXor;
            zeroExt = 1'b1;
          end
          decodePkg::opAndni: begin
            aluOp   = decodePkg::aluAndn;
            zeroExt = 1'b1;
          end
          decodePkg::opRoli: aluOp = decodePkg::aluRol;
          decodePkg::opSlli: aluOp = decodePkg::aluSll;
          decodePkg::opRori: aluOp = decodePkg::aluRor;
          decodePkg::opSrli: aluOp = decodePkg::aluSrl;
          default:           aluOp = decodePkg::aluAdd;
        endcase
      end
      decodePkg::opSt, decodePkg::opStu: begin
        memEn  = 1'b1;
        memWrt = 1'b1;
        bSrc   = bSrcImm5; // Address Rs + imm5
        regWrt = (opcode == decodePkg::opStu); // Updated address back to Rs
      end
      decodePkg::opLd: begin
        memEn  = 1'b1;
        regWrt = 1'b1;
        regSrc = regSrcMem;
        bSrc   = bSrcImm5;
        regDst = decodePkg::dstRt;
      end
      decodePkg::opSlbi: begin
        slbi   = 1'b1;
        regWrt = 1'b1;
        aluOp  = decodePkg::aluSlbi;
        bSrc   = bSrcImm8;
      end
      decodePkg::opLbi: begin
        regWrt = 1'b1;
        aluOp  = decodePkg::aluPassB;
        bSrc   = bSrcImm8;
      end
      decodePkg::opBtr: begin
        btr    = 1'b1;
        regWrt = 1'b1;
        aluOp  = decodePkg::aluBtr;
        regDst = decodePkg::dstRd;
      end
      decodePkg::opAlu, decodePkg::opShift: begin
        regWrt = 1'b1;
        regDst = decodePkg::dstRd;
        aluOp  = (opcode == decodePkg::opAlu) ? decodePkg::aluArith : decodePkg::aluShift;
      end
      decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco: begin
        set    = 1'b1;
        regWrt = 1'b1;
        regSrc = regSrcCond;
        regDst = decodePkg::dstRd;
        sub    = (opcode != decodePkg::opSco); // Sco looks at the add carry
        invB   = (opcode != decodePkg::opSco);
      end
      decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez: begin
        branch = 1'b1;
        aluOp  = decodePkg::aluPassA;
      end
      decodePkg::opJ, decodePkg::opJal: begin
        jmp    = 1'b1;
        immSrc = 1'b1; // PC-relative imm11 target
        regWrt = (opcode == decodePkg::opJal);
        regSrc = regSrcPc;
        regDst = decodePkg::dstR7;
      end
      decodePkg::opJr, decodePkg::opJalr: begin
        jmp    = 1'b1;
        aluJmp = 1'b1; // Target Rs + imm8 from the ALU
        bSrc   = bSrcImm8;
        regWrt = (opcode == decodePkg::opJalr);
        regSrc = regSrcPc;
        regDst = decodePkg::dstR7;
      end
      default: ; // opNop and unknown opcodes
    endcase
  end

endmodule

`default_nettype wire

/* rtl/regFileBypass.sv */
// Register file with two read ports, one write port and write-to-read bypass
`default_nettype none

module regFileBypass #(
  parameter int numRegs = 8 // Power of two, indices fold modulo the count
) (
  input  wire                     clk,
  input  wire                     arstN,
  input  wire  decodePkg::regIdxT read1RegSel,
  input  wire  decodePkg::regIdxT read2RegSel,
  input  wire  decodePkg::regIdxT writeRegSel,
  input  wire  decodePkg::wordT   writeData,
  input  wire                     writeEn,
  output decodePkg::wordT         read1Data,
  output decodePkg::wordT         read2Data
);

  localparam int idxW = $clog2(numRegs);

  decodePkg::wordT regs [numRegs];

  logic [idxW-1:0] rd1Idx;
  logic [idxW-1:0] rd2Idx;
  logic [idxW-1:0] wrIdx;

  assign rd1Idx = read1RegSel[idxW-1:0]; // Low bits give the folded index
  assign rd2Idx = read2RegSel[idxW-1:0];
  assign wrIdx  = writeRegSel[idxW-1:0];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[wrIdx] <= writeData;
    end
  end

  // A write in flight wins over the stored value
  always_comb begin
    if (writeEn && (wrIdx == rd1Idx)) begin
      read1Data = writeData;
    end else begin
      read1Data = regs[rd1Idx];
    end
    if (writeEn && (wrIdx == rd2Idx)) begin
      read2Data = writeData;
    end else begin
      read2Data = regs[rd2Idx];
    end
  end

  // Write-back stage must always name a real register
  writeSelKnown: assert property (@(posedge clk) disable iff (!arstN)
    writeEn |-> !$isunknown(writeRegSel))
    else $error("write enable with unknown register select");

endmodule

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simName=decodeStageSim

rm -f "$logFile"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module decodeStageTb -f decodeStage.f -o "$simName" > "$logFile" 2>&1 \
  && ./obj_dir/"$simName" >> "$logFile" 2>&1

grep -qx "all tests passed" "$logFile" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see $logFile"; exit 1; }

/* verification/decodeStageTb.sv */
// Decode stage testbench with clock, reset, stimulus phases, reference model and concurrent checks
`default_nettype none

module decodeStageTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int regCount    = 8;
  localparam int regPhase    = 120;
  localparam int decodePhase = 150;
  localparam int loadUseRuns = 40;  // Two cycles each
  localparam int flushRuns   = 20;  // At most five cycles each
  localparam int stallPhase  = 60;
  localparam int mixedPhase  = 100;
  localparam int stimCycles  = regPhase + decodePhase + 2 * loadUseRuns + 5 * flushRuns +
                               stallPhase + mixedPhase;
  localparam int maxCycles   = 2 * stimCycles;

  logic clk;
  logic arstN;
  logic regWrtIn, dataMemStall, instrMemStall, pcSrcX, memRd;
  decodePkg::instrT  instructionIn;
  decodePkg::regIdxT writeRegSelIn;
  decodePkg::regIdxT registerRtIdEx;
  decodePkg::wordT   writeData;

  decodePkg::wordT   readData1, readData2, imm5Ext, imm8Ext, imm11Ext;
  logic [1:0]        bSrc, regSrc, functOut, brchCndSel;
  decodePkg::aluOpT  aluOp;
  decodePkg::regIdxT registerRs, registerRt, writeRegSelOut;
  decodePkg::instrT  instructionOut;
  logic immSrc, invA, invB, memWrt, regWrtOut, branch, set, sub, memEn;
  logic aluJmp, slbi, halt, btr, jmp, hazard, flush;

  // Reference state
  decodePkg::wordT   refRegs [regCount];
  decodePkg::instrT  heldInstr;
  logic              heldHaz;
  logic              flushPending; // Second flush slot still owed

  logic              expHazard, expFlush, expZeroExt, expRegWrt, expMemWrt;
  logic [11:0]       expFlags;
  decodePkg::instrT  expInstr;
  decodePkg::regIdxT expWrSel;
  decodePkg::wordT   expImm5, expImm8, expImm11, expRd1, expRd2;
  int                cycleCount = 0;

  decodeStage #(
    .numRegs (regCount)
  ) dut_i (.*);

  always #4 clk = ~clk;

  // Opcodes that write a register
  function automatic logic writesReg(input decodePkg::opcodeT op);
    case (op)
      decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
      decodePkg::opRoli, decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli,
      decodePkg::opLd, decodePkg::opStu, decodePkg::opSlbi, decodePkg::opLbi,
      decodePkg::opBtr, decodePkg::opAlu, decodePkg::opShift, decodePkg::opSeq,
      decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco, decodePkg::opJal,
      decodePkg::opJalr: return 1'b1;
      default: return 1'b0; // Non-writers and unknown opcodes
    endcase
  endfunction

  // Order halt, slbi, btr, branch, jmp, memEn, set, immSrc, aluJmp, sub, invA, invB
  function automatic logic [11:0] expectedFlags(input decodePkg::opcodeT op);
    logic [11:0] flags;
    flags[11] = (op == decodePkg::opHalt);
    flags[10] = (op == decodePkg::opSlbi);
    flags[9]  = (op == decodePkg::opBtr);
    flags[8]  = op inside {decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz,
                           decodePkg::opBgez};
    flags[7]  = op inside {decodePkg::opJ, decodePkg::opJr, decodePkg::opJal, decodePkg::opJalr};
    flags[6]  = op inside {decodePkg::opSt, decodePkg::opStu, decodePkg::opLd};
    flags[5]  = op inside {decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle,
                           decodePkg::opSco};
    flags[4]  = op inside {decodePkg::opJ, decodePkg::opJal};   // Target from imm11
    flags[3]  = op inside {decodePkg::opJr, decodePkg::opJalr}; // Target from Rs + imm8
    flags[2]  = op inside {decodePkg::opSubi, decodePkg::opSeq, decodePkg::opSlt,
                           decodePkg::opSle};
    flags[1]  = (op == decodePkg::opSubi); // imm - Rs
    flags[0]  = op inside {decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle};
    return flags;
  endfunction

  function automatic decodePkg::regIdxT destIndex(input decodePkg::instrT instr);
    decodePkg::opcodeT op;
    op = instr[15:11];
    case (op)
      decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
      decodePkg::opRoli, decodePkg::opSlli, decodePkg::opRori, decodePkg::opSrli,
      decodePkg::opLd: return instr[7:5];
      decodePkg::opAlu, decodePkg::opShift, decodePkg::opBtr, decodePkg::opSeq,
      decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco: return instr[4:2];
      decodePkg::opLbi, decodePkg::opSlbi, decodePkg::opStu: return instr[10:8];
      default: return 3'd7; // Link register for jal and jalr
    endcase
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < regCount; i++) begin
        refRegs[i] <= '0;
      end
      heldInstr    <= decodePkg::nopInstr;
      heldHaz      <= 1'b0;
      flushPending <= 1'b0;
    end else begin
      if (regWrtIn) begin
        refRegs[writeRegSelIn] <= writeData;
      end
      heldInstr <= instructionIn;
      heldHaz   <= expHazard;
      if (pcSrcX) begin
        flushPending <= 1'b1;
      end else if (!(dataMemStall || instrMemStall)) begin
        flushPending <= 1'b0; // Held while any stall is up
      end
    end
  end

  always_comb begin
    expHazard = memRd && ((registerRtIdEx == instructionIn[10:8]) ||
                          (registerRtIdEx == instructionIn[7:5]));
    expFlush  = pcSrcX || flushPending;
    if (expHazard || expFlush || dataMemStall) begin
      expInstr = decodePkg::nopInstr;
    end else if (heldHaz && (heldInstr != decodePkg::nopInstr)) begin
      expInstr = heldInstr; // Replay
    end else begin
      expInstr = instructionIn;
    end
  end

  always_comb begin
    expZeroExt = (expInstr[15:11] == decodePkg::opXori) ||
                 (expInstr[15:11] == decodePkg::opAndni);
    expImm5    = expZeroExt ? {11'd0, expInstr[4:0]} : {{11{expInstr[4]}}, expInstr[4:0]};
    expImm8    = expZeroExt ? {8'd0, expInstr[7:0]} : {{8{expInstr[7]}}, expInstr[7:0]};
    expImm11   = {{5{expInstr[10]}}, expInstr[10:0]};
    expRegWrt  = writesReg(expInstr[15:11]);
    expWrSel   = destIndex(expInstr);
    expMemWrt  = (expInstr[15:11] == decodePkg::opSt) || (expInstr[15:11] == decodePkg::opStu);
    expFlags   = expectedFlags(expInstr[15:11]);
    expRd1     = (regWrtIn && (writeRegSelIn == expInstr[10:8])) ? writeData :
                 refRegs[expInstr[10:8]];
    expRd2     = (regWrtIn && (writeRegSelIn == expInstr[7:5])) ? writeData :
                 refRegs[expInstr[7:5]];
  end

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic reportMismatch(input string what);
    stopWithFailure($sformatf("ERROR at %0d ns: %s", $time, what));
  endtask

  afterReset: assert property (@(posedge clk)
    $rose(arstN) |-> (!flush && (readData1 == '0) && (readData2 == '0)))
    else reportMismatch("flush or register reads not clear after reset");
  readsMatch: assert property (@(posedge clk) disable iff (!arstN)
    (readData1 == expRd1) && (readData2 == expRd2))
    else reportMismatch("register read data differs from the last write");
  hazardMatches: assert property (@(posedge clk) disable iff (!arstN) hazard == expHazard)
    else reportMismatch("hazard differs from the load-use rule");
  flushMatches: assert property (@(posedge clk) disable iff (!arstN) flush == expFlush)
    else reportMismatch("flush differs from the branch flush rule");
  instrMatches: assert property (@(posedge clk) disable iff (!arstN)
    instructionOut == expInstr)
    else reportMismatch("instructionOut differs from the select rule");
  fieldsMatch: assert property (@(posedge clk) disable iff (!arstN)
    (registerRs == expInstr[10:8]) && (registerRt == expInstr[7:5]) &&
    (functOut == expInstr[1:0]) && (brchCndSel == expInstr[12:11]))
    else reportMismatch("register index or pass-through field wrong");
  immsMatch: assert property (@(posedge clk) disable iff (!arstN)
    (imm5Ext == expImm5) && (imm8Ext == expImm8) && (imm11Ext == expImm11))
    else reportMismatch("immediate extension wrong");
  writeCtlMatches: assert property (@(posedge clk) disable iff (!arstN)
    (regWrtOut == expRegWrt) && (memWrt == expMemWrt) &&
    (!expRegWrt || (writeRegSelOut == expWrSel)))
    else reportMismatch("regWrtOut, memWrt or writeRegSelOut wrong");
  flagsMatch: assert property (@(posedge clk) disable iff (!arstN)
    {halt, slbi, btr, branch, jmp, memEn, set, immSrc, aluJmp, sub, invA, invB} == expFlags)
    else reportMismatch("one-bit control signal differs from the opcode");
  bubbleIdle: assert property (@(posedge clk) disable iff (!arstN)
    (expInstr == decodePkg::nopInstr) |-> ({aluOp, bSrc, regSrc} == '0))
    else reportMismatch("NOP slot drives an ALU, operand or write-back select");
  flushBubble: assert property (@(posedge clk) disable iff (!arstN)
    flush |-> ((instructionOut == decodePkg::nopInstr) && !regWrtOut))
    else reportMismatch("instruction leaked through a flush");
  flushExtends: assert property (@(posedge clk) disable iff (!arstN)
    (flush && !pcSrcX && (dataMemStall || instrMemStall)) |=> flush)
    else reportMismatch("flush dropped during a stall");
  stallBubble: assert property (@(posedge clk) disable iff (!arstN)
    dataMemStall |-> ((instructionOut == decodePkg::nopInstr) && !memWrt))
    else reportMismatch("instruction leaked through a data stall");
  replayAfterHazard: assert property (@(posedge clk) disable iff (!arstN)
    ($past(hazard) && !hazard && !flush && !dataMemStall &&
     ($past(instructionIn) != decodePkg::nopInstr)) |-> (instructionOut == $past(instructionIn)))
    else reportMismatch("held instruction not replayed after hazard");

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      stopWithFailure($sformatf("Timeout: run still busy after %0d clock cycles", cycleCount));
    end
  end

  task automatic writeAndReadRegs(input int cycles);
    decodePkg::instrT instr;
    for (int i = 0; i < cycles; i++) begin
      instr = 16'($urandom);
      @(posedge clk);
      instructionIn <= instr;
      regWrtIn      <= ($urandom_range(3) != 0);
      writeRegSelIn <= (i % 4 == 0) ? instr[10:8] : 3'($urandom); // Same-cycle bypass
      writeData     <= 16'($urandom);
    end
  endtask

  task automatic decodeEveryOpcode(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      regWrtIn      <= 1'b0;
      instructionIn <= {5'(i % 32), 11'($urandom)};
    end
  endtask

  task automatic loadUseBubbles(input int runs);
    decodePkg::instrT held;
    for (int i = 0; i < runs; i++) begin
      held = (i % 8 == 7) ? decodePkg::nopInstr : 16'($urandom);
      @(posedge clk);
      instructionIn  <= held;
      memRd          <= 1'b1;
      registerRtIdEx <= (i % 2 == 1) ? held[10:8] : held[7:5];
      @(posedge clk);
      instructionIn  <= 16'($urandom);
      memRd          <= 1'b0;
    end
  endtask

  task automatic branchFlushes(input int runs);
    int stallLen;
    for (int i = 0; i < runs; i++) begin
      stallLen = $urandom_range(2);
      @(posedge clk);
      pcSrcX        <= 1'b1;
      instructionIn <= 16'($urandom);
      @(posedge clk);
      pcSrcX        <= (i % 7 == 3); // Occasional back-to-back branch
      instrMemStall <= (i % 3 == 1);
      dataMemStall  <= (i % 3 == 2);
      instructionIn <= 16'($urandom);
      repeat (stallLen) @(posedge clk);
      @(posedge clk);
      pcSrcX        <= 1'b0;
      instrMemStall <= 1'b0;
      dataMemStall  <= 1'b0;
    end
  endtask

  task automatic dataStalls(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      dataMemStall  <= ($urandom_range(1) == 1);
      instructionIn <= (i % 2 == 0) ? {decodePkg::opSt, 11'($urandom)} : 16'($urandom);
    end
  endtask

  task automatic mixedTraffic(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      instructionIn  <= 16'($urandom);
      regWrtIn       <= ($urandom_range(1) == 1);
      writeRegSelIn  <= 3'($urandom);
      writeData      <= 16'($urandom);
      pcSrcX         <= ($urandom_range(7) == 0);
      memRd          <= ($urandom_range(3) == 0);
      registerRtIdEx <= 3'($urandom);
      dataMemStall   <= ($urandom_range(5) == 0);
      instrMemStall  <= ($urandom_range(5) == 0);
    end
  endtask

  initial begin
    void'($urandom(32'hd721_790a));
    clk            = 1'b0;
    arstN          = 1'b0;
    instructionIn  = decodePkg::nopInstr;
    regWrtIn       = 1'b0;
    writeRegSelIn  = '0;
    writeData      = '0;
    dataMemStall   = 1'b0;
    instrMemStall  = 1'b0;
    pcSrcX         = 1'b0;
    memRd          = 1'b0;
    registerRtIdEx = '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    writeAndReadRegs(regPhase);
    decodeEveryOpcode(decodePhase);
    loadUseBubbles(loadUseRuns);
    branchFlushes(flushRuns);
    dataStalls(stallPhase);
    mixedTraffic(mixedPhase);
    @(posedge clk);
    pcSrcX       <= 1'b0;
    dataMemStall <= 1'b0;
    memRd        <= 1'b0;
    repeat (3) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
